/* hdl/exe_pkg.sv */
`default_nettype none

package exe_pkg;

    // --------------------------------------------------
    // widths and multicycle timing
    // --------------------------------------------------
    localparam int XLEN       = 32;
    localparam int REG_W      = 5;
    localparam int OP_W       = 5;
    localparam int SHAMT_W    = $clog2(XLEN);
    localparam int MUL_CYCLES = 2;
    // 32 divide iterations plus one sign fix-up cycle
    localparam int DIV_CYCLES = 33;
    localparam int CNT_W      = $clog2(DIV_CYCLES + 1);

    // --------------------------------------------------
    // opcodes
    // --------------------------------------------------
    typedef enum logic [OP_W-1:0] {
        OP_ADDU  = 5'd0,
        OP_SUBU  = 5'd1,
        OP_AND   = 5'd2,
        OP_OR    = 5'd3,
        OP_XOR   = 5'd4,
        OP_NOR   = 5'd5,
        OP_SLT   = 5'd6,
        OP_SLTU  = 5'd7,
        OP_SLL   = 5'd8,
        OP_SRL   = 5'd9,
        OP_SRA   = 5'd10,
        OP_LUI   = 5'd11,
        // multiply/divide path
        OP_MULT  = 5'd16,
        OP_MULTU = 5'd17,
        OP_DIV   = 5'd18,
        OP_DIVU  = 5'd19,
        OP_MFHI  = 5'd20,
        OP_MFLO  = 5'd21
    } exe_op_e;

    // decoded operation with its operands
    typedef struct packed {
        logic [XLEN-1:0]  pc;
        exe_op_e          op;
        logic [XLEN-1:0]  src_a;
        logic [XLEN-1:0]  src_b;
        logic [REG_W-1:0] wnum;
    } exe_op_t;

    // one register write, as seen at writeback
    typedef struct packed {
        logic [XLEN-1:0]  pc;
        logic [REG_W-1:0] wnum;
        logic [XLEN-1:0]  wdata;
    } wb_rec_t;

    // what the multiply/divide unit keeps of a started operation
    typedef struct packed {
        exe_op_e         op;
        logic [XLEN-1:0] src_a;
        logic [XLEN-1:0] src_b;
    } md_op_t;

    function automatic logic is_md_op(exe_op_e op);
        return op inside {OP_MULT, OP_MULTU, OP_DIV, OP_DIVU, OP_MFHI, OP_MFLO};
    endfunction

endpackage

`default_nettype wire

/* hdl/pipe_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  wire            clk,
    input  wire            rst_n,
    input  wire            in_valid,
    output logic           in_allowin,
    input  wire payload_t  in_data,
    output logic           out_valid,
    input  wire            out_allowin,
    output payload_t       out_data
);

    logic     valid_q;
    payload_t data_q;

    // take a new entry when empty or when the current one leaves now
    assign in_allowin = !valid_q || out_allowin;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (in_allowin) begin
            valid_q <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_allowin) begin
            data_q <= in_data;
        end
    end

    assign out_valid = valid_q;
    assign out_data  = data_q;

endmodule

`default_nettype wire

/* hdl/exe_issue.sv */
`timescale 1ns/1ps
`default_nettype none

module exe_issue (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   in_valid,
    output logic                  in_allowin,
    input  wire exe_pkg::exe_op_t in_op,
    output logic                  alu_valid,
    input  wire                   alu_allowin,
    output logic                  md_valid,
    input  wire                   md_allowin,
    output exe_pkg::exe_op_t      disp_op
);

    import exe_pkg::*;

    logic    issue_valid;
    logic    issue_allowin;
    logic    to_md;
    exe_op_t issue_op;

    // --------------------------------------------------
    // issue register
    // --------------------------------------------------
    pipe_reg #(
        .payload_t(exe_op_t)
    ) u_issue_reg (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_allowin  (in_allowin),
        .in_data     (in_op),
        .out_valid   (issue_valid),
        .out_allowin (issue_allowin),
        .out_data    (issue_op)
    );

    // --------------------------------------------------
    // steering
    // --------------------------------------------------
    assign to_md = is_md_op(issue_op.op);

    // exactly one path sees the valid
    assign alu_valid = issue_valid && !to_md;
    assign md_valid  = issue_valid && to_md;

    // stall on the chosen path only
    assign issue_allowin = to_md ? md_allowin : alu_allowin;

    // both paths read the same payload
    assign disp_op = issue_op;

endmodule

`default_nettype wire

/* hdl/alu_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_unit (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   op_valid,
    output logic                  op_allowin,
    input  wire exe_pkg::exe_op_t op,
    output logic                  res_valid,
    input  wire                   res_allowin,
    output exe_pkg::wb_rec_t      res
);

    import exe_pkg::*;

    logic [SHAMT_W-1:0] shamt;
    logic [XLEN-1:0]    alu_out;
    wb_rec_t            alu_rec;

    assign shamt = op.src_b[SHAMT_W-1:0];

    // --------------------------------------------------
    // ALU
    // --------------------------------------------------
    always_comb begin
        case (op.op)
            OP_ADDU: alu_out = op.src_a + op.src_b;
            OP_SUBU: alu_out = op.src_a - op.src_b;
            OP_AND:  alu_out = op.src_a & op.src_b;
            OP_OR:   alu_out = op.src_a | op.src_b;
            OP_XOR:  alu_out = op.src_a ^ op.src_b;
            OP_NOR:  alu_out = ~(op.src_a | op.src_b);
            OP_SLT: begin
                alu_out = {{(XLEN-1){1'b0}}, $signed(op.src_a) < $signed(op.src_b)};
            end
            OP_SLTU: begin
                alu_out = {{(XLEN-1){1'b0}}, op.src_a < op.src_b};
            end
            OP_SLL:  alu_out = op.src_a << shamt;
            OP_SRL:  alu_out = op.src_a >> shamt;
            OP_SRA:  alu_out = $unsigned($signed(op.src_a) >>> shamt);
            // immediate sits in the low half of src_b
            OP_LUI:  alu_out = {op.src_b[XLEN/2-1:0], {(XLEN/2){1'b0}}};
            default: alu_out = '0;
        endcase
    end

    always_comb begin
        alu_rec.pc    = op.pc;
        alu_rec.wnum  = op.wnum;
        alu_rec.wdata = alu_out;
    end

    // --------------------------------------------------
    // execute register
    // --------------------------------------------------
    pipe_reg #(
        .payload_t(wb_rec_t)
    ) u_alu_reg (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (op_valid),
        .in_allowin  (op_allowin),
        .in_data     (alu_rec),
        .out_valid   (res_valid),
        .out_allowin (res_allowin),
        .out_data    (res)
    );

endmodule

`default_nettype wire

/* hdl/mult_div.sv */
`timescale 1ns/1ps
`default_nettype none

module mult_div (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   op_valid,
    output logic                  op_allowin,
    input  wire exe_pkg::exe_op_t op,
    output logic                  res_valid,
    input  wire                   res_allowin,
    output exe_pkg::wb_rec_t      res
);

    import exe_pkg::*;

    logic [XLEN-1:0]        hi_q;
    logic [XLEN-1:0]        lo_q;
    logic                   busy_q;
    logic [CNT_W-1:0]       cnt_q;
    md_op_t                 start_q;
    logic                   is_read;
    logic                   rd_valid;
    logic                   rd_allowin;
    logic                   start;
    logic                   start_div;
    logic                   start_sgn;
    logic [XLEN-1:0]        abs_a;
    logic [XLEN-1:0]        abs_b;
    logic                   run_div;
    logic                   run_sgn;
    logic signed [XLEN:0]   mul_a;
    logic signed [XLEN:0]   mul_b;
    logic signed [2*XLEN+1:0] mul_full;
    logic [2*XLEN-1:0]      prod_q;
    logic [XLEN-1:0]        rem_q;
    logic [XLEN-1:0]        quo_q;
    logic [XLEN-1:0]        dvs_q;
    logic [XLEN:0]          rem_shift;
    logic [XLEN:0]          trial;
    logic [XLEN-1:0]        quo_fix;
    logic [XLEN-1:0]        rem_fix;
    wb_rec_t                rd_rec;

    // --------------------------------------------------
    // accept / start
    // --------------------------------------------------
    assign is_read    = (op.op == OP_MFHI) || (op.op == OP_MFLO);
    // nothing gets in while a multiply or divide runs
    assign op_allowin = !busy_q && (!is_read || rd_allowin);
    assign start      = op_valid && op_allowin && !is_read;
    assign start_div  = (op.op == OP_DIV) || (op.op == OP_DIVU);
    assign start_sgn  = (op.op == OP_MULT) || (op.op == OP_DIV);

    // divider works on magnitudes
    assign abs_a = (start_sgn && op.src_a[XLEN-1]) ? -op.src_a : op.src_a;
    assign abs_b = (start_sgn && op.src_b[XLEN-1]) ? -op.src_b : op.src_b;

    assign run_div = (start_q.op == OP_DIV) || (start_q.op == OP_DIVU);
    assign run_sgn = (start_q.op == OP_MULT) || (start_q.op == OP_DIV);

    // --------------------------------------------------
    // multiplier and divider datapath
    // --------------------------------------------------
    assign mul_a    = {run_sgn & start_q.src_a[XLEN-1], start_q.src_a};
    assign mul_b    = {run_sgn & start_q.src_b[XLEN-1], start_q.src_b};
    assign mul_full = mul_a * mul_b;

    // one restoring step
    assign rem_shift = {rem_q, quo_q[XLEN-1]};
    assign trial     = rem_shift - {1'b0, dvs_q};

    // quotient truncates toward zero, remainder follows the dividend
    assign quo_fix = (run_sgn && (start_q.src_a[XLEN-1] ^ start_q.src_b[XLEN-1])) ?
                     -quo_q : quo_q;
    assign rem_fix = (run_sgn && start_q.src_a[XLEN-1]) ? -rem_q : rem_q;

    always_ff @(posedge clk) begin
        if (start) begin
            start_q.op    <= op.op;
            start_q.src_a <= op.src_a;
            start_q.src_b <= op.src_b;
            rem_q         <= '0;
            quo_q         <= abs_a;
            dvs_q         <= abs_b;
        end else if (busy_q) begin
            prod_q <= mul_full[2*XLEN-1:0];
            // last count is the fix-up cycle
            if (run_div && cnt_q != CNT_W'(1)) begin
                if (!trial[XLEN]) begin
                    rem_q <= trial[XLEN-1:0];
                    quo_q <= {quo_q[XLEN-2:0], 1'b1};
                end else begin
                    rem_q <= rem_shift[XLEN-1:0];
                    quo_q <= {quo_q[XLEN-2:0], 1'b0};
                end
            end
        end
    end

    // --------------------------------------------------
    // busy counter and HI/LO
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
            hi_q   <= '0;
            lo_q   <= '0;
        end else if (start) begin
            busy_q <= 1'b1;
            cnt_q  <= start_div ? CNT_W'(DIV_CYCLES) : CNT_W'(MUL_CYCLES);
        end else if (busy_q) begin
            cnt_q <= cnt_q - 1'b1;
            if (cnt_q == CNT_W'(1)) begin
                busy_q <= 1'b0;
                if (run_div) begin
                    hi_q <= rem_fix;
                    lo_q <= quo_fix;
                end else begin
                    hi_q <= prod_q[2*XLEN-1:XLEN];
                    lo_q <= prod_q[XLEN-1:0];
                end
            end
        end
    end

    // --------------------------------------------------
    // MFHI / MFLO read stage
    // --------------------------------------------------
    assign rd_valid = op_valid && is_read && !busy_q;

    always_comb begin
        rd_rec.pc    = op.pc;
        rd_rec.wnum  = op.wnum;
        rd_rec.wdata = (op.op == OP_MFHI) ? hi_q : lo_q;
    end

    pipe_reg #(
        .payload_t(wb_rec_t)
    ) u_rd_reg (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (rd_valid),
        .in_allowin  (rd_allowin),
        .in_data     (rd_rec),
        .out_valid   (res_valid),
        .out_allowin (res_allowin),
        .out_data    (res)
    );

endmodule

`default_nettype wire

/* hdl/wb_merge.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_merge (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   alu_valid,
    output logic                  alu_allowin,
    input  wire exe_pkg::wb_rec_t alu_res,
    input  wire                   md_valid,
    output logic                  md_allowin,
    input  wire exe_pkg::wb_rec_t md_res,
    output logic                  out_valid,
    input  wire                   out_allowin,
    output exe_pkg::wb_rec_t      out_wb
);

    import exe_pkg::*;

    logic    merge_valid;
    logic    merge_allowin;
    logic    sel_md;
    logic    md_first_q;
    wb_rec_t merge_rec;

    // md result has been waiting longer than the ALU one
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            md_first_q <= 1'b0;
        end else begin
            md_first_q <= md_valid && !md_allowin && (sel_md || alu_allowin);
        end
    end

    // oldest result goes first when both paths hold one
    assign sel_md      = md_valid && (!alu_valid || md_first_q);
    assign merge_valid = alu_valid || md_valid;
    assign merge_rec   = sel_md ? md_res : alu_res;

    assign alu_allowin = merge_allowin && !sel_md;
    assign md_allowin  = merge_allowin && sel_md;

    // writeback register
    pipe_reg #(
        .payload_t(wb_rec_t)
    ) u_wb_reg (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (merge_valid),
        .in_allowin  (merge_allowin),
        .in_data     (merge_rec),
        .out_valid   (out_valid),
        .out_allowin (out_allowin),
        .out_data    (out_wb)
    );

endmodule

`default_nettype wire

/* hdl/exe_top.sv */
`timescale 1ns/1ps
`default_nettype none

module exe_top (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   in_valid,
    output logic                  in_allowin,
    input  wire exe_pkg::exe_op_t in_op,
    output logic                  out_valid,
    input  wire                   out_allowin,
    output exe_pkg::wb_rec_t      out_wb
);

    import exe_pkg::*;

    // --------------------------------------------------
    // issue to execute
    // --------------------------------------------------
    logic    alu_valid;
    logic    alu_allowin;
    logic    md_valid;
    logic    md_allowin;
    exe_op_t disp_op;

    // execute to writeback
    logic    alu_res_valid;
    logic    alu_res_allowin;
    wb_rec_t alu_res;
    logic    md_res_valid;
    logic    md_res_allowin;
    wb_rec_t md_res;

    exe_issue u_exe_issue (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_allowin  (in_allowin),
        .in_op       (in_op),
        .alu_valid   (alu_valid),
        .alu_allowin (alu_allowin),
        .md_valid    (md_valid),
        .md_allowin  (md_allowin),
        .disp_op     (disp_op)
    );

    alu_unit u_alu_unit (
        .clk         (clk),
        .rst_n       (rst_n),
        .op_valid    (alu_valid),
        .op_allowin  (alu_allowin),
        .op          (disp_op),
        .res_valid   (alu_res_valid),
        .res_allowin (alu_res_allowin),
        .res         (alu_res)
    );

    mult_div u_mult_div (
        .clk         (clk),
        .rst_n       (rst_n),
        .op_valid    (md_valid),
        .op_allowin  (md_allowin),
        .op          (disp_op),
        .res_valid   (md_res_valid),
        .res_allowin (md_res_allowin),
        .res         (md_res)
    );

    wb_merge u_wb_merge (
        .clk         (clk),
        .rst_n       (rst_n),
        .alu_valid   (alu_res_valid),
        .alu_allowin (alu_res_allowin),
        .alu_res     (alu_res),
        .md_valid    (md_res_valid),
        .md_allowin  (md_res_allowin),
        .md_res      (md_res),
        .out_valid   (out_valid),
        .out_allowin (out_allowin),
        .out_wb      (out_wb)
    );

endmodule

`default_nettype wire

/* tb/exe_model.svh */
`ifndef EXE_MODEL_SVH
`define EXE_MODEL_SVH

// HI/LO as the program sees them, updated in issue order
logic [XLEN-1:0] model_hi = '0;
logic [XLEN-1:0] model_lo = '0;

// records still owed by the DUT, oldest first
wb_rec_t expect_q [$];

function automatic logic [XLEN-1:0] alu_expect(input exe_op_t o);
    logic [4:0]        sh;
    logic [2*XLEN-1:0] ext;
    logic [XLEN-1:0]   r;
    sh  = o.src_b[4:0];
    ext = {{XLEN{o.src_a[XLEN-1]}}, o.src_a};
    case (o.op)
        OP_ADDU: r = o.src_a + o.src_b;
        OP_SUBU: r = o.src_a + ~o.src_b + 32'd1;
        OP_AND:  r = o.src_a & o.src_b;
        OP_OR:   r = o.src_a | o.src_b;
        OP_XOR:  r = o.src_a ^ o.src_b;
        OP_NOR:  r = ~o.src_a & ~o.src_b;
        // differing signs decide by the sign of a alone
        OP_SLT:  r = (o.src_a[XLEN-1] != o.src_b[XLEN-1]) ? {31'd0, o.src_a[XLEN-1]} :
                     {31'd0, o.src_a < o.src_b};
        OP_SLTU: r = {31'd0, o.src_a < o.src_b};
        OP_SLL:  r = o.src_a << sh;
        OP_SRL:  r = o.src_a >> sh;
        // low word of a sign-extended 64 bit shift
        OP_SRA: begin
            ext = ext >> sh;
            r   = ext[XLEN-1:0];
        end
        OP_LUI:  r = {o.src_b[15:0], 16'h0000};
        default: r = 'x;
    endcase
    return r;
endfunction

task automatic model_accept(input exe_op_t o);
    logic signed [2*XLEN-1:0] sa;
    logic signed [2*XLEN-1:0] sb;
    logic [2*XLEN-1:0]        ua;
    logic [2*XLEN-1:0]        ub;
    logic [2*XLEN-1:0]        prod;
    wb_rec_t                  rec;
    sa = {{XLEN{o.src_a[XLEN-1]}}, o.src_a};
    sb = {{XLEN{o.src_b[XLEN-1]}}, o.src_b};
    ua = {{XLEN{1'b0}}, o.src_a};
    ub = {{XLEN{1'b0}}, o.src_b};
    rec.pc   = o.pc;
    rec.wnum = o.wnum;
    if (!is_md_op(o.op)) begin
        rec.wdata = alu_expect(o);
        expect_q.push_back(rec);
    end else begin
        case (o.op)
            OP_MULT: begin
                prod     = sa * sb;
                model_hi = prod[2*XLEN-1:XLEN];
                model_lo = prod[XLEN-1:0];
            end
            OP_MULTU: begin
                prod     = ua * ub;
                model_hi = prod[2*XLEN-1:XLEN];
                model_lo = prod[XLEN-1:0];
            end
            // 64 bit signed divide truncates toward zero
            OP_DIV: begin
                prod     = sa / sb;
                model_lo = prod[XLEN-1:0];
                prod     = sa % sb;
                model_hi = prod[XLEN-1:0];
            end
            OP_DIVU: begin
                model_lo = o.src_a / o.src_b;
                model_hi = o.src_a % o.src_b;
            end
            OP_MFHI: begin
                rec.wdata = model_hi;
                expect_q.push_back(rec);
            end
            default: begin
                rec.wdata = model_lo;
                expect_q.push_back(rec);
            end
        endcase
    end
endtask

`endif

/* tb/tb_exe_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_exe_top;

    import exe_pkg::*;
    `include "exe_model.svh"

    localparam int ISSUE_TIMEOUT = 300;
    localparam int DRAIN_TIMEOUT = 500;

    logic    clk = 1'b0;
    logic    rst_n;
    logic    in_valid;
    logic    in_allowin;
    exe_op_t in_op;
    logic    out_valid;
    logic    out_allowin;
    wb_rec_t out_wb;

    string           test_name = "reset";
    logic [XLEN-1:0] pc_next   = 32'hbfc0_0000;
    logic            bp_en     = 1'b0;
    int              stall_left = 0;

    exe_op_e alu_ops [0:11] = '{OP_ADDU, OP_SUBU, OP_AND, OP_OR, OP_XOR, OP_NOR,
                                OP_SLT, OP_SLTU, OP_SLL, OP_SRL, OP_SRA, OP_LUI};
    exe_op_e all_ops [0:17] = '{OP_ADDU, OP_SUBU, OP_AND, OP_OR, OP_XOR, OP_NOR,
                                OP_SLT, OP_SLTU, OP_SLL, OP_SRL, OP_SRA, OP_LUI,
                                OP_MULT, OP_MULTU, OP_DIV, OP_DIVU, OP_MFHI, OP_MFLO};

    exe_top u_exe_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_allowin  (in_allowin),
        .in_op       (in_op),
        .out_valid   (out_valid),
        .out_allowin (out_allowin),
        .out_wb      (out_wb)
    );

    always #20 clk = ~clk;

    // --------------------------------------------------
    // checks
    // --------------------------------------------------
    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_wb(input string name, input wb_rec_t exp, input wb_rec_t act);
        if (act !== exp) begin
            stop_with_failure($sformatf(
                "[FAIL] %s: expected pc=%h wnum=%0d wdata=%h, actual pc=%h wnum=%0d wdata=%h",
                name, exp.pc, exp.wnum, exp.wdata, act.pc, act.wnum, act.wdata));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_with_failure($sformatf("[FAIL] %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    // transfers are sampled mid-cycle, where inputs and outputs are settled
    always @(negedge clk) begin
        if (rst_n === 1'b1) begin
            if (in_valid && in_allowin) begin
                model_accept(in_op);
            end
            if (out_valid && out_allowin) begin
                if (expect_q.size() == 0) begin
                    stop_with_failure($sformatf(
                        "%s: a writeback record for pc %h came out with none expected",
                        test_name, out_wb.pc));
                end else begin
                    check_wb(test_name, expect_q.pop_front(), out_wb);
                end
            end
        end
    end

    // --------------------------------------------------
    // stimulus
    // --------------------------------------------------
    task automatic next_cycle();
        @(posedge clk);
        #2;
        if (!bp_en) begin
            out_allowin = 1'b1;
        end else if (stall_left > 0) begin
            out_allowin = 1'b0;
            stall_left  = stall_left - 1;
        end else if ($urandom % 6 == 0) begin
            out_allowin = 1'b0;
            stall_left  = $urandom % 12;
        end else begin
            out_allowin = 1'b1;
        end
    endtask

    function automatic exe_op_t make_op(input exe_op_e op, input logic [XLEN-1:0] pc);
        exe_op_t o;
        o.pc    = pc;
        o.op    = op;
        o.src_a = $urandom;
        o.src_b = $urandom;
        o.wnum  = REG_W'($urandom);
        // narrow divisors give quotients with more bits set
        if (op == OP_DIV || op == OP_DIVU) begin
            o.src_b = o.src_b >> ($urandom % 32);
            while (o.src_b == '0) begin
                o.src_b = $urandom;
            end
        end
        return o;
    endfunction

    task automatic issue_op(input exe_op_e op, input int gap_max);
        exe_op_t o;
        int      gap;
        int      waited;
        logic    taken;
        o       = make_op(op, pc_next);
        pc_next = pc_next + 32'd4;
        gap     = (gap_max > 0) ? int'($urandom % (gap_max + 1)) : 0;
        repeat (gap) next_cycle();
        in_valid = 1'b1;
        in_op    = o;
        waited   = 0;
        taken    = 1'b0;
        while (!taken) begin
            #8;
            taken = in_allowin;
            next_cycle();
            waited = waited + 1;
            if (!taken && waited > ISSUE_TIMEOUT) begin
                stop_with_failure($sformatf("%s: operation at pc %h was never accepted",
                                            test_name, o.pc));
            end
        end
        in_valid = 1'b0;
    endtask

    initial begin
        int waited;
        void'($urandom(32'hc135));
        rst_n       = 1'b0;
        in_valid    = 1'b0;
        in_op       = '0;
        out_allowin = 1'b1;
        repeat (16) @(posedge clk);
        #2;
        rst_n = 1'b1;
        check_flag("reset out_valid", 1'b0, out_valid);
        check_flag("reset in_allowin", 1'b1, in_allowin);

        test_name = "alu random";
        repeat (240) issue_op(alu_ops[$urandom % 12], 2);

        // read HI/LO straight behind each multiply
        test_name = "mult hi lo";
        repeat (30) begin
            issue_op(($urandom % 2) ? OP_MULT : OP_MULTU, 2);
            issue_op(OP_MFHI, 0);
            issue_op(OP_MFLO, 1);
        end

        test_name = "div lo hi";
        repeat (30) begin
            issue_op(($urandom % 2) ? OP_DIV : OP_DIVU, 2);
            issue_op(OP_MFHI, 0);
            issue_op(OP_MFLO, 1);
        end

        test_name = "back pressure mix";
        bp_en = 1'b1;
        repeat (400) issue_op(all_ops[$urandom % 18], 2);
        bp_en = 1'b0;

        // let everything in flight come out
        waited = 0;
        while (expect_q.size() != 0) begin
            next_cycle();
            waited = waited + 1;
            if (waited > DRAIN_TIMEOUT) begin
                stop_with_failure("expected records were still missing when the drain wait expired");
            end
        end
        repeat (40) next_cycle();

        if (out_valid) begin
            stop_with_failure("records were left in flight at the end of the run");
        end else begin
            $display("All tests passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+tb
hdl/exe_pkg.sv
hdl/pipe_reg.sv
hdl/exe_issue.sv
hdl/alu_unit.sv
hdl/mult_div.sv
hdl/wb_merge.sv
hdl/exe_top.sv
tb/tb_exe_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the exe_top testbench with Verilator, run it, and judge the log

cd "$(dirname "$0")" || exit 1

log=sim.log
rm -f "$log"

verilator --binary --timing -Wno-fatal -j 0 \
    --top-module tb_exe_top -f verilog.f -o vsim_exe_top \
    > build.log 2>&1 \
    && { ./obj_dir/vsim_exe_top > "$log" 2>&1; cat "$log"; } \
    || { cat build.log; echo "build failed"; exit 1; }

grep -q "Some tests failed" "$log" && { echo "simulation FAILED"; exit 1; }
grep -q "All tests passed" "$log" || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"
exit 0
